//--- Bender.yml
package:
  name: mips_pipeline

sources:
  - files:
      - verilog/mips_pkg.sv
      - verilog/instr_queue.sv
      - verilog/reg_file.sv
      - verilog/decode_stage.sv
      - verilog/hazard_unit.sv
      - verilog/execute_stage.sv
      - verilog/memory_stage.sv
      - verilog/mips_pipeline.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/clock_gen.sv
      - bench/tb_mips_pipeline.sv

//--- bench/clock_gen.sv
// free-running testbench clock
`timescale 1ns/100ps
`default_nettype none

module clock_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);
    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- bench/mips_ref_model.svh
// architectural model of the core, one instruction at a time
// included inside the testbench module, uses its localparams
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

word_t model_regs [NUM_REGS];
word_t model_mem  [DMEM_WORDS];

function automatic void apply_instr(input word_t instr, output logic exp_write,
                                    output reg_addr_t exp_reg, output word_t exp_data);
    word_t       a;
    word_t       b;
    word_t       imm;
    int unsigned idx;
    a         = model_regs[instr[25:21]];
    b         = model_regs[instr[20:16]];
    imm       = {{16{instr[15]}}, instr[15:0]};
    idx       = ((a + imm) >> 2) % DMEM_WORDS;   // word index of a load or store
    exp_write = 1'b0;
    exp_reg   = '0;
    exp_data  = '0;
    case (instr[31:26])
        R_TYPE:
        begin
            exp_write = 1'b1;
            exp_reg   = instr[15:11];
            case (instr[5:0])
                SUB:     exp_data = a - b;
                AND:     exp_data = a & b;
                OR:      exp_data = a | b;
                SLT:     exp_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default: exp_data = a + b;
            endcase
        end
        ADDI:
        begin
            exp_write = 1'b1;
            exp_reg   = instr[20:16];
            exp_data  = a + imm;
        end
        LW:
        begin
            exp_write = 1'b1;
            exp_reg   = instr[20:16];
            exp_data  = model_mem[idx];
        end
        SW:      model_mem[idx] = b;
        default: ;  // unknown opcode, no effect
    endcase
    // r0 keeps zero and its writes retire as no-writes
    if (exp_reg == '0)
        exp_write = 1'b0;
    if (exp_write)
        model_regs[exp_reg] = exp_data;
endfunction

`endif

//--- bench/tb_mips_pipeline.sv
// testbench for the pipelined core: sends programs under credit flow control
// and checks every retired instruction against an architectural model
`timescale 1ns/100ps
`default_nettype none

module tb_mips_pipeline
    import mips_pkg::*;
();
    localparam int QUEUE_DEPTH = 4;
    localparam int DMEM_WORDS  = 64;

    logic      SYS_clk;
    logic      SYS_reset;
    logic      instr_valid;
    word_t     instr_word;
    logic      instr_credit;
    logic      ret_valid;
    logic      ret_write;
    reg_addr_t ret_reg;
    word_t     ret_data;

    word_t     prog_q [$];      // not yet sent
    string     name_q [$];
    word_t     sent_q [$];      // sent, waiting to retire
    string     sent_name_q [$];
    int        total;
    int        credits;
    int        credit_pulses;
    int        sent_count;
    int        retired_count;
    int        error_count;
    int        cycles;
    int        cycle_limit;

    `include "mips_ref_model.svh"

    clock_gen #(.PERIOD_NS(4.0)) clk_i (.clk(SYS_clk));

    mips_pipeline #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .DMEM_WORDS  (DMEM_WORDS)
    ) dut_i (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .instr_valid  (instr_valid),
        .instr_word   (instr_word),
        .instr_credit (instr_credit),
        .ret_valid    (ret_valid),
        .ret_write    (ret_write),
        .ret_reg      (ret_reg),
        .ret_data     (ret_data)
    );

    function automatic word_t r_type_word(input funct_e f, input reg_addr_t rd,
                                          input reg_addr_t rs, input reg_addr_t rt);
        return {R_TYPE, rs, rt, rd, 5'd0, f};
    endfunction

    function automatic word_t i_type_word(input opcode_e op, input reg_addr_t rt,
                                          input reg_addr_t rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic queue_instr(input string tname, input word_t w);
        prog_q.push_back(w);
        name_q.push_back(tname);
    endtask

    // each instruction reads the one or two results before it
    task automatic build_chain_test();
        funct_e    ops [5] = '{ADD, SUB, AND, OR, SLT};
        reg_addr_t prev1;
        reg_addr_t prev2;
        reg_addr_t dest;
        prev2 = 5'd1;
        prev1 = 5'd2;
        queue_instr("chain", i_type_word(ADDI, prev2, 5'd0, 16'($urandom)));
        queue_instr("chain", i_type_word(ADDI, prev1, prev2, 16'($urandom)));
        for (int i = 0; i < 40; i++)
        begin
            dest = reg_addr_t'($urandom_range(1, 15));
            if (i % 4 == 0)
                queue_instr("chain", i_type_word(ADDI, dest, prev1, 16'($urandom)));
            else
                queue_instr("chain", r_type_word(ops[$urandom_range(0, 4)], dest, prev1, prev2));
            prev2 = prev1;
            prev1 = dest;
        end
    endtask

    task automatic build_memory_test();
        int unsigned addr [8];
        for (int i = 0; i < 8; i++)
        begin
            addr[i] = $urandom_range(0, DMEM_WORDS - 1);
            queue_instr("memory", i_type_word(ADDI, reg_addr_t'(10 + i), 5'd0, 16'($urandom)));
            queue_instr("memory", i_type_word(SW, reg_addr_t'(10 + i), 5'd0, 16'(addr[i] * 4)));
        end
        for (int i = 0; i < 8; i++)
        begin
            queue_instr("memory", i_type_word(LW, 5'd20, 5'd0, 16'(addr[i] * 4)));
            if (i % 2 == 0)     // dependent add right after the load
                queue_instr("memory", r_type_word(ADD, 5'd21, 5'd20, reg_addr_t'(10 + i)));
            else
                queue_instr("memory", r_type_word(ADD, 5'd21, reg_addr_t'(10 + i), 5'd20));
        end
    endtask

    task automatic build_r0_test();
        queue_instr("r0", i_type_word(ADDI, 5'd0, 5'd0, 16'h1234));
        queue_instr("r0", r_type_word(ADD, 5'd0, 5'd1, 5'd2));
        queue_instr("r0", r_type_word(ADD, 5'd5, 5'd0, 5'd0));
        queue_instr("r0", i_type_word(ADDI, 5'd6, 5'd0, 16'h0007));
        queue_instr("r0", r_type_word(OR, 5'd7, 5'd0, 5'd6));
        queue_instr("r0", 32'hfc00_0000);   // unknown opcode
    endtask

    // load-use pairs stall the core so the burst runs out of credits
    task automatic build_burst_test();
        funct_e      ops [5] = '{ADD, SUB, AND, OR, SLT};
        int unsigned kind;
        reg_addr_t   src;
        logic [15:0] offs;
        for (int i = 0; i < 40; i++)
        begin
            kind = $urandom_range(0, 2);
            if (kind == 0)
                queue_instr("burst", i_type_word(ADDI, reg_addr_t'($urandom_range(1, 15)),
                            reg_addr_t'($urandom_range(0, 15)), 16'($urandom)));
            else if (kind == 1)
                queue_instr("burst", r_type_word(ops[$urandom_range(0, 4)],
                            reg_addr_t'($urandom_range(1, 15)),
                            reg_addr_t'($urandom_range(0, 15)),
                            reg_addr_t'($urandom_range(0, 15))));
            else
            begin
                src  = reg_addr_t'($urandom_range(1, 15));
                offs = 16'($urandom_range(0, DMEM_WORDS - 1) * 4);
                queue_instr("burst", i_type_word(SW, src, 5'd0, offs));
                queue_instr("burst", i_type_word(LW, 5'd20, 5'd0, offs));
                queue_instr("burst", r_type_word(ADD, src, 5'd20, src));
            end
        end
    endtask

    task automatic check_idle(input string phase);
        if (instr_credit !== 1'b0)
        begin
            error_count++;
            $display("FAILED %s: instr_credit expected 0 actual %b", phase, instr_credit);
        end
        if (ret_valid !== 1'b0)
        begin
            error_count++;
            $display("FAILED %s: ret_valid expected 0 actual %b", phase, ret_valid);
        end
    endtask

    // one falling edge of the producer: collect credit, maybe send
    task automatic producer_step();
        if (instr_credit === 1'b1)
        begin
            credits++;
            credit_pulses++;
        end
        if (credits > QUEUE_DEPTH)
        begin
            error_count++;
            $display("ERROR: more credits returned than instructions outstanding");
        end
        instr_valid = 1'b0;
        if (prog_q.size() > 0 && credits > 0)
        begin
            if (name_q[0] == "burst" || $urandom_range(0, 3) != 0)  // bursts never idle
            begin
                instr_valid = 1'b1;
                instr_word  = prog_q.pop_front();
                sent_q.push_back(instr_word);
                sent_name_q.push_back(name_q.pop_front());
                credits--;
                sent_count++;
            end
        end
    endtask

    task automatic check_retirement();
        word_t     instr;
        string     tname;
        logic      exp_write;
        reg_addr_t exp_reg;
        word_t     exp_data;
        if (sent_q.size() == 0)
        begin
            error_count++;
            $display("ERROR: an instruction retired with none outstanding");
        end
        else
        begin
            instr = sent_q.pop_front();
            tname = sent_name_q.pop_front();
            apply_instr(instr, exp_write, exp_reg, exp_data);
            retired_count++;
            if (ret_write !== exp_write)
            begin
                error_count++;
                $display("FAILED %s: ret_write expected %b actual %b (instr %h)",
                         tname, exp_write, ret_write, instr);
            end
            if (exp_write && ret_reg !== exp_reg)
            begin
                error_count++;
                $display("FAILED %s: ret_reg expected %0d actual %0d (instr %h)",
                         tname, exp_reg, ret_reg, instr);
            end
            if (exp_write && ret_data !== exp_data)
            begin
                error_count++;
                $display("FAILED %s: ret_data expected %h actual %h (instr %h)",
                         tname, exp_data, ret_data, instr);
            end
        end
    endtask

    always @(negedge SYS_clk)
    begin
        if (!SYS_reset && ret_valid === 1'b1)
            check_retirement();
    end

    initial
    begin
        void'($urandom(32'hb762));
        SYS_reset     = 1'b1;
        instr_valid   = 1'b0;
        instr_word    = '0;
        credits       = QUEUE_DEPTH;
        credit_pulses = 0;
        sent_count    = 0;
        retired_count = 0;
        error_count   = 0;
        cycles        = 0;
        for (int i = 0; i < NUM_REGS; i++)
            model_regs[i] = '0;

        build_chain_test();
        build_memory_test();
        build_r0_test();
        build_burst_test();
        total       = prog_q.size();
        cycle_limit = 4 * total + 200;

        @(posedge SYS_clk);     // registers are unknown before the first edge
        repeat (16)
        begin
            @(negedge SYS_clk);
            check_idle("reset");
        end
        SYS_reset = 1'b0;
        repeat (2)
        begin
            @(negedge SYS_clk);
            check_idle("after reset");
        end

        while (retired_count < total && cycles < cycle_limit)
        begin
            @(negedge SYS_clk);
            cycles++;
            producer_step();
        end

        if (cycles >= cycle_limit)
        begin
            error_count++;
            $display("ERROR: timeout after %0d cycles, %0d of %0d instructions retired",
                     cycles, retired_count, total);
        end
        if (credit_pulses != sent_count)
        begin
            error_count++;
            $display("FAILED credits: pulses expected %0d actual %0d", sent_count, credit_pulses);
        end
        if (sent_q.size() != 0)
        begin
            error_count++;
            $display("ERROR: %0d sent instructions never retired", sent_q.size());
        end
        $display("errors: %0d  sent: %0d  retired: %0d  credits: %0d",
                 error_count, sent_count, retired_count, credit_pulses);
        if (error_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+bench
verilog/mips_pkg.sv
verilog/instr_queue.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/hazard_unit.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/mips_pipeline.sv
bench/clock_gen.sv
bench/tb_mips_pipeline.sv

//--- verilog/decode_stage.sv
// decode stage: instruction register, control decode, immediate
// sign extension and destination select, plus register file read
`timescale 1ns/100ps
`default_nettype none

module decode_stage
    import mips_pkg::*;
(
    input  wire logic      SYS_clk,
    input  wire logic      SYS_reset,
    input  wire logic      issue_valid,
    input  wire word_t     issue_word,
    input  wire logic      stall,
    input  wire logic      wb_write,
    input  wire reg_addr_t wb_dest,
    input  wire word_t     wb_result,
    output logic           d_valid,
    output reg_addr_t      d_rs,
    output reg_addr_t      d_rt,
    output word_t          d_rs_data,
    output word_t          d_rt_data,
    output word_t          d_imm,
    output reg_addr_t      d_dest,
    output logic           d_reg_write,
    output logic           d_mem_read,
    output logic           d_mem_write,
    output logic           d_alu_src_imm,
    output funct_e         d_funct,
    output opcode_e        d_opcode
);
    word_t d_word;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            d_valid <= 1'b0;
            d_word  <= '0;
        end
        else if (!stall)    // hold on load-use
        begin
            d_valid <= issue_valid;
            d_word  <= issue_word;
        end
    end

    assign d_opcode = opcode_e'(d_word[31:26]);
    assign d_funct  = funct_e'(d_word[5:0]);
    assign d_rs     = d_valid ? d_word[25:21] : '0; // bubbles name no sources
    assign d_rt     = d_valid ? d_word[20:16] : '0;
    assign d_imm    = {{(XLEN-16){d_word[15]}}, d_word[15:0]};

    always_comb
    begin
        d_reg_write   = 1'b0;
        d_mem_read    = 1'b0;
        d_mem_write   = 1'b0;
        d_alu_src_imm = 1'b0;
        d_dest        = '0;
        if (d_valid)
        begin
            case (d_opcode)
                R_TYPE:
                begin
                    d_reg_write = 1'b1;
                    d_dest      = d_word[15:11];    // rd
                end
                ADDI:
                begin
                    d_reg_write   = 1'b1;
                    d_alu_src_imm = 1'b1;
                    d_dest        = d_word[20:16];  // rt
                end
                LW:
                begin
                    d_reg_write   = 1'b1;
                    d_mem_read    = 1'b1;
                    d_alu_src_imm = 1'b1;
                    d_dest        = d_word[20:16];
                end
                SW:
                begin
                    d_mem_write   = 1'b1;
                    d_alu_src_imm = 1'b1;
                end
                default: ;  // unknown opcode retires as no-op
            endcase
            if (d_dest == '0)
                d_reg_write = 1'b0; // r0 results are dropped
        end
    end

    reg_file regs_i (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rs_addr   (d_rs),
        .rt_addr   (d_rt),
        .wr_en     (wb_write),
        .wr_addr   (wb_dest),
        .wr_data   (wb_result),
        .rs_data   (d_rs_data),
        .rt_data   (d_rt_data)
    );

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
// execute stage: pipeline register, operand forwarding,
// alu control and the alu itself
`timescale 1ns/100ps
`default_nettype none

module execute_stage
    import mips_pkg::*;
(
    input  wire logic      SYS_clk,
    input  wire logic      SYS_reset,
    input  wire logic      stall,
    input  wire logic      d_valid,
    input  wire reg_addr_t d_rs,
    input  wire reg_addr_t d_rt,
    input  wire word_t     d_rs_data,
    input  wire word_t     d_rt_data,
    input  wire word_t     d_imm,
    input  wire reg_addr_t d_dest,
    input  wire logic      d_reg_write,
    input  wire logic      d_mem_read,
    input  wire logic      d_mem_write,
    input  wire logic      d_alu_src_imm,
    input  wire funct_e    d_funct,
    input  wire opcode_e   d_opcode,
    input  wire fwd_sel_e  fwd_a,
    input  wire fwd_sel_e  fwd_b,
    input  wire word_t     mem_result,
    input  wire word_t     wb_result,
    output logic           e_valid,
    output reg_addr_t      e_rs,
    output reg_addr_t      e_rt,
    output reg_addr_t      e_dest,
    output logic           e_reg_write,
    output logic           e_mem_read,
    output logic           e_mem_write,
    output word_t          e_result,
    output word_t          e_store_data
);
    word_t   e_rs_data;
    word_t   e_rt_data;
    word_t   e_imm;
    logic    e_alu_src_imm;
    funct_e  e_funct;
    opcode_e e_opcode;
    word_t   op_a;
    word_t   op_b;
    alu_op_e alu_op;

    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
                                      input word_t from_mem, input word_t from_wb);
        case (sel)
            FWD_MEM: return from_mem;
            FWD_WB:  return from_wb;
            default: return reg_val;
        endcase
    endfunction

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || stall) // stall inserts a bubble
        begin
            e_valid     <= 1'b0;
            e_reg_write <= 1'b0;
            e_mem_read  <= 1'b0;
            e_mem_write <= 1'b0;
        end
        else
        begin
            e_valid     <= d_valid;
            e_reg_write <= d_reg_write;
            e_mem_read  <= d_mem_read;
            e_mem_write <= d_mem_write;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            e_rs          <= '0;
            e_rt          <= '0;
            e_dest        <= '0;
            e_rs_data     <= '0;
            e_rt_data     <= '0;
            e_imm         <= '0;
            e_alu_src_imm <= 1'b0;
            e_funct       <= ADD;
            e_opcode      <= R_TYPE;
        end
        else
        begin
            e_rs          <= d_rs;
            e_rt          <= d_rt;
            e_dest        <= d_dest;
            e_rs_data     <= d_rs_data;
            e_rt_data     <= d_rt_data;
            e_imm         <= d_imm;
            e_alu_src_imm <= d_alu_src_imm;
            e_funct       <= d_funct;
            e_opcode      <= d_opcode;
        end
    end

    assign op_a         = fwd_mux(fwd_a, e_rs_data, mem_result, wb_result);
    assign e_store_data = fwd_mux(fwd_b, e_rt_data, mem_result, wb_result);
    assign op_b         = e_alu_src_imm ? e_imm : e_store_data;

    always_comb
    begin
        alu_op = ALU_ADD;   // addi, lw and sw add base and offset
        if (e_opcode == R_TYPE)
        begin
            case (e_funct)
                ADD:     alu_op = ALU_ADD;
                SUB:     alu_op = ALU_SUB;
                AND:     alu_op = ALU_AND;
                OR:      alu_op = ALU_OR;
                SLT:     alu_op = ALU_SLT;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    always_comb
    begin
        case (alu_op)
            ALU_SUB: e_result = op_a - op_b;
            ALU_AND: e_result = op_a & op_b;
            ALU_OR:  e_result = op_a | op_b;
            ALU_SLT: e_result = ($signed(op_a) < $signed(op_b)) ? word_t'(1) : '0;
            default: e_result = op_a + op_b;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/hazard_unit.sv
// hazard unit: operand forwarding selects for execute
// and one-cycle stall for a load followed by a dependent instruction
`timescale 1ns/100ps
`default_nettype none

module hazard_unit
    import mips_pkg::*;
(
    input  wire logic      d_valid,
    input  wire reg_addr_t d_rs,
    input  wire reg_addr_t d_rt,
    input  wire logic      e_valid,
    input  wire reg_addr_t e_rs,
    input  wire reg_addr_t e_rt,
    input  wire logic      e_mem_read,
    input  wire reg_addr_t e_dest,
    input  wire logic      m_reg_write,
    input  wire reg_addr_t m_dest,
    input  wire logic      w_reg_write,
    input  wire reg_addr_t w_dest,
    output fwd_sel_e       fwd_a,
    output fwd_sel_e       fwd_b,
    output logic           stall
);
    logic load_in_ex;

    // youngest producer wins, r0 is never forwarded
    function automatic fwd_sel_e pick_src(input reg_addr_t src);
        fwd_sel_e sel;
        sel = FWD_NONE;
        if (m_reg_write && m_dest != '0 && m_dest == src)
            sel = FWD_MEM;
        else if (w_reg_write && w_dest != '0 && w_dest == src)
            sel = FWD_WB;
        return sel;
    endfunction

    always_comb
    begin
        fwd_a = pick_src(e_rs);
        fwd_b = pick_src(e_rt);
    end

    assign load_in_ex = e_valid && e_mem_read && (e_dest != '0);
    assign stall      = load_in_ex && (e_dest == d_rs || e_dest == d_rt);

    // decode zeroes the source indices of a bubble, so no load can match them
    always_comb
    begin
        a_stall_needs_decode: assert final (!stall || d_valid)
            else $error("stall raised with an empty decode stage");
    end

endmodule

`default_nettype wire

//--- verilog/instr_queue.sv
// instruction queue with credit flow control
// each entry handed to decode returns one credit to the producer
`timescale 1ns/100ps
`default_nettype none

module instr_queue
    import mips_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire logic  SYS_clk,
    input  wire logic  SYS_reset,
    input  wire logic  instr_valid,
    input  wire word_t instr_word,
    input  wire logic  stall,
    output logic       instr_credit,
    output logic       issue_valid,
    output word_t      issue_word
);
    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    word_t            entries [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;

    assign issue_valid = (count != '0);
    assign issue_word  = entries[rd_ptr];       // head of queue
    assign pop         = issue_valid && !stall; // decode takes it this edge

    always_ff @(posedge SYS_clk)
    begin
        if (instr_valid)
            entries[wr_ptr] <= instr_word;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            instr_credit <= 1'b0;
        end
        else
        begin
            if (instr_valid)
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({instr_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            instr_credit <= pop;    // one credit per issued entry
        end
    end

    // a producer honouring its credits never finds the queue full
    a_no_push_full: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !(instr_valid && count == CNT_W'(QUEUE_DEPTH)))
        else $error("instruction pushed into a full queue");

endmodule

`default_nettype wire

//--- verilog/memory_stage.sv
// memory stage with data memory, followed by the writeback register
// which also drives the retirement port
`timescale 1ns/100ps
`default_nettype none

module memory_stage
    import mips_pkg::*;
#(
    parameter int DMEM_WORDS = 64
) (
    input  wire logic      SYS_clk,
    input  wire logic      SYS_reset,
    input  wire logic      e_valid,
    input  wire reg_addr_t e_dest,
    input  wire logic      e_reg_write,
    input  wire logic      e_mem_read,
    input  wire logic      e_mem_write,
    input  wire word_t     e_result,
    input  wire word_t     e_store_data,
    output logic           m_reg_write,
    output reg_addr_t      m_dest,
    output word_t          mem_result,
    output logic           wb_write,
    output reg_addr_t      wb_dest,
    output word_t          wb_result,
    output logic           ret_valid,
    output logic           ret_write,
    output reg_addr_t      ret_reg,
    output word_t          ret_data
);
    localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    word_t            dmem [DMEM_WORDS];
    logic             m_valid;
    logic             m_mem_read;
    logic             m_mem_write;
    word_t            m_alu_result;
    word_t            m_store_data;
    logic [IDX_W-1:0] m_index;
    logic             w_valid;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            m_valid      <= 1'b0;
            m_reg_write  <= 1'b0;
            m_mem_read   <= 1'b0;
            m_mem_write  <= 1'b0;
            m_dest       <= '0;
            m_alu_result <= '0;
            m_store_data <= '0;
        end
        else
        begin
            m_valid      <= e_valid;
            m_reg_write  <= e_reg_write;
            m_mem_read   <= e_mem_read;
            m_mem_write  <= e_mem_write;
            m_dest       <= e_dest;
            m_alu_result <= e_result;
            m_store_data <= e_store_data;
        end
    end

    assign m_index = m_alu_result[IDX_W+1:2];  // word address

    always_ff @(posedge SYS_clk)
    begin
        if (m_mem_write)
            dmem[m_index] <= m_store_data;
    end

    assign mem_result = m_mem_read ? dmem[m_index] : m_alu_result;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            w_valid   <= 1'b0;
            wb_write  <= 1'b0;
            wb_dest   <= '0;
            wb_result <= '0;
        end
        else
        begin
            w_valid   <= m_valid;
            wb_write  <= m_reg_write;
            wb_dest   <= m_dest;
            wb_result <= mem_result;
        end
    end

    assign ret_valid = w_valid;
    assign ret_write = wb_write;
    assign ret_reg   = wb_dest;
    assign ret_data  = wb_result;

    // decode never marks one instruction as both load and store
    a_rd_wr_excl: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !(m_mem_read && m_mem_write))
        else $error("memory read and write asserted together");

endmodule

`default_nettype wire

//--- verilog/mips_pipeline.sv
// pipelined integer core fed from a credit-based instruction queue
// retired instructions leave through the writeback register
`timescale 1ns/100ps
`default_nettype none

module mips_pipeline
    import mips_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4,
    parameter int DMEM_WORDS  = 64
) (
    input  wire logic      SYS_clk,
    input  wire logic      SYS_reset,
    input  wire logic      instr_valid,
    input  wire word_t     instr_word,
    output logic           instr_credit,
    output logic           ret_valid,
    output logic           ret_write,
    output reg_addr_t      ret_reg,
    output word_t          ret_data
);
    logic      stall;
    logic      issue_valid;
    word_t     issue_word;

    logic      d_valid;
    reg_addr_t d_rs;
    reg_addr_t d_rt;
    word_t     d_rs_data;
    word_t     d_rt_data;
    word_t     d_imm;
    reg_addr_t d_dest;
    logic      d_reg_write;
    logic      d_mem_read;
    logic      d_mem_write;
    logic      d_alu_src_imm;
    funct_e    d_funct;
    opcode_e   d_opcode;

    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;

    logic      e_valid;
    reg_addr_t e_rs;
    reg_addr_t e_rt;
    reg_addr_t e_dest;
    logic      e_reg_write;
    logic      e_mem_read;
    logic      e_mem_write;
    word_t     e_result;
    word_t     e_store_data;

    logic      m_reg_write;
    reg_addr_t m_dest;
    word_t     mem_result;
    logic      wb_write;        // writeback port, also forwarding source
    reg_addr_t wb_dest;
    word_t     wb_result;

    instr_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue_i (.*);

    decode_stage decode_i (.*);

    hazard_unit hazard_i (
        .*,
        .w_reg_write (wb_write),
        .w_dest      (wb_dest)
    );

    execute_stage execute_i (.*);

    memory_stage #(.DMEM_WORDS(DMEM_WORDS)) memory_i (.*);

endmodule

`default_nettype wire

//--- verilog/mips_pkg.sv
// shared widths, word types and instruction encodings
// for the pipelined integer core
`default_nettype none

package mips_pkg;

    parameter int XLEN     = 32;    // data and instruction width
    parameter int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // primary opcode, bits 31:26
    typedef enum logic [5:0] {
        R_TYPE = 6'h00,
        ADDI   = 6'h08,
        LW     = 6'h23,
        SW     = 6'h2b
    } opcode_e;

    // r-type function field, bits 5:0
    typedef enum logic [5:0] {
        ADD = 6'h20,
        SUB = 6'h22,
        AND = 6'h24,
        OR  = 6'h25,
        SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    // where an execute operand comes from
    typedef enum logic [1:0] {
        FWD_NONE,   // register file value
        FWD_MEM,    // result in memory stage
        FWD_WB      // result in writeback register
    } fwd_sel_e;

endpackage

`default_nettype wire

//--- verilog/reg_file.sv
// 32-entry register file, r0 reads as zero
// a write in the same cycle is visible on the read ports
`timescale 1ns/100ps
`default_nettype none

module reg_file
    import mips_pkg::*;
(
    input  wire logic      SYS_clk,
    input  wire logic      SYS_reset,
    input  wire reg_addr_t rs_addr,
    input  wire reg_addr_t rt_addr,
    input  wire logic      wr_en,
    input  wire reg_addr_t wr_addr,
    input  wire word_t     wr_data,
    output word_t          rs_data,
    output word_t          rt_data
);
    word_t regs [NUM_REGS];
    logic  wr_live;

    assign wr_live = wr_en && (wr_addr != '0);  // r0 never written

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wr_live)
            regs[wr_addr] <= wr_data;
    end

    assign rs_data = (wr_live && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_data = (wr_live && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

`default_nettype wire
